/* files.f */
src/raster_pkg.sv
src/clear_sweep.sv
src/depth_test.sv
src/frame_store.sv
src/scan_out.sv
src/raster_backend.sv
test/tb_clock_gen.sv
test/raster_backend_assert.sv
test/raster_backend_tb.sv

/* src/clear_sweep.sv */
`timescale 1ns/1ps

module clear_sweep import raster_pkg::*; #(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input  logic      clk_render,
    input  logic      rst_render,
    input  logic      frame_start,
    input  color12_t  fill_color,
    input  fragment_t frag_in,
    output fragment_t frag_out,
    output logic      swap,
    output logic      busy
);

    localparam logic [coord_w-1:0] last_x = coord_w'(WIDTH - 1);
    localparam logic [coord_w-1:0] last_y = coord_w'(HEIGHT - 1);

    sweep_state_e       state;
    logic [coord_w-1:0] x_cnt;
    logic [coord_w-1:0] y_cnt;
    logic               last_pixel;
    fragment_t          clear_frag;

    assign busy = (state == SWEEP_RUN);

    // A frame start is only taken while no sweep is running
    assign swap = frame_start && !busy;

    assign last_pixel = (x_cnt == last_x) && (y_cnt == last_y);

    // Clear fragment always overwrites, compare off
    always_comb begin
        clear_frag.valid         = 1'b1;
        clear_frag.x             = x_cnt;
        clear_frag.y             = y_cnt;
        clear_frag.depth         = depth_max;
        clear_frag.color         = expand_color(fill_color);
        clear_frag.compare_depth = 1'b0;
    end

    // ------------------------------------------------------------------------
    // Sweep FSM, row-major over the frame
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            state <= SWEEP_IDLE;
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            case (state)
                SWEEP_IDLE: begin
                    if (swap) begin
                        state <= SWEEP_RUN;
                        x_cnt <= '0;
                        y_cnt <= '0;
                    end
                end
                SWEEP_RUN: begin
                    if (last_pixel) begin
                        state <= SWEEP_IDLE;
                    end
                    if (x_cnt == last_x) begin
                        x_cnt <= '0;
                        y_cnt <= y_cnt + 1'b1;
                    end else begin
                        x_cnt <= x_cnt + 1'b1;
                    end
                end
                default: state <= SWEEP_IDLE;
            endcase
        end
    end

    // External fragments are dropped while the sweep owns the pipe
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            frag_out <= '0;
        end else if (busy) begin
            frag_out <= clear_frag;
        end else begin
            frag_out <= frag_in;
        end
    end

endmodule

/* src/depth_test.sv */
`timescale 1ns/1ps

module depth_test import raster_pkg::*; #(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input  logic      clk_render,
    input  logic      rst_render,
    input  fragment_t frag,
    output fb_write_t fb_wr
);

    localparam int depth_n = WIDTH * HEIGHT;
    localparam int addr_w  = $clog2(depth_n);

    logic [depth_w-1:0] depth_mem [depth_n];

    logic [addr_w-1:0]  in_addr;
    logic               in_range;

    // Stage 1 registers
    logic               s1_valid;
    fragment_t          s1_frag;
    logic [addr_w-1:0]  s1_addr;
    logic [depth_w-1:0] s1_depth;

    // Stage 2 decision
    depth_op_e          s2_op;
    logic               s2_write;
    logic               fwd_hit;

    assign in_addr  = addr_w'(pixel_index(frag.x, frag.y, WIDTH));
    assign in_range = (frag.x < coord_w'(WIDTH)) && (frag.y < coord_w'(HEIGHT));

    // Stage 2 is writing the pixel that stage 1 reads in this cycle
    assign fwd_hit = s2_write && (s1_addr == in_addr);

    // ------------------------------------------------------------------------
    // Stage 1: depth read
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            s1_valid <= 1'b0;
        end else begin
            // Off-screen fragments never reach the buffers
            s1_valid <= frag.valid && in_range;
        end
    end

    always_ff @(posedge clk_render) begin
        s1_frag <= frag;
        s1_addr <= in_addr;
        if (fwd_hit) begin
            s1_depth <= s1_frag.depth;
        end else begin
            s1_depth <= depth_mem[in_addr];
        end
    end

    // ------------------------------------------------------------------------
    // Stage 2: compare and write
    // ------------------------------------------------------------------------
    always_comb begin
        if (!s1_valid) begin
            s2_op = OP_NONE;
        end else if (!s1_frag.compare_depth) begin
            s2_op = OP_FORCE;
        end else if (s1_frag.depth < s1_depth) begin
            s2_op = OP_PASS;
        end else begin
            // Ties keep the earlier fragment
            s2_op = OP_REJECT;
        end
    end

    assign s2_write = (s2_op == OP_FORCE) || (s2_op == OP_PASS);

    always_ff @(posedge clk_render) begin
        if (s2_write) begin
            depth_mem[s1_addr] <= s1_frag.depth;
        end
    end

    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            fb_wr <= '0;
        end else begin
            fb_wr.en    <= s2_write;
            fb_wr.x     <= s1_frag.x;
            fb_wr.y     <= s1_frag.y;
            fb_wr.color <= s1_frag.color;
        end
    end

endmodule

/* src/frame_store.sv */
`timescale 1ns/1ps

module frame_store import raster_pkg::*; #(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input  logic               clk_render,
    input  logic               rst_render,
    input  logic               swap,
    input  fb_write_t          fb_wr,
    input  logic [coord_w-1:0] rd_x,
    input  logic [coord_w-1:0] rd_y,
    output color16_t           rd_color
);

    localparam int pix_n  = WIDTH * HEIGHT;
    localparam int addr_w = $clog2(pix_n);

    color16_t          fb0_mem [pix_n];
    color16_t          fb1_mem [pix_n];

    // Low selects buffer 0 as the displayed one
    logic              front_sel;
    logic [addr_w-1:0] wr_addr;
    logic [addr_w-1:0] rd_addr;
    logic              rd_ok;

    assign wr_addr = addr_w'(pixel_index(fb_wr.x, fb_wr.y, WIDTH));
    assign rd_addr = addr_w'(pixel_index(rd_x, rd_y, WIDTH));
    assign rd_ok   = (rd_x < coord_w'(WIDTH)) && (rd_y < coord_w'(HEIGHT));

    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            front_sel <= 1'b0;
        end else if (swap) begin
            front_sel <= ~front_sel;
        end
    end

    // ------------------------------------------------------------------------
    // Back buffer write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render) begin
        if (fb_wr.en && front_sel) begin
            fb0_mem[wr_addr] <= fb_wr.color;
        end
    end

    always_ff @(posedge clk_render) begin
        if (fb_wr.en && !front_sel) begin
            fb1_mem[wr_addr] <= fb_wr.color;
        end
    end

    // ------------------------------------------------------------------------
    // Front buffer read port, one cycle latency
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_render) begin
        if (!rd_ok) begin
            // Past the right or bottom edge of the frame
            rd_color <= '0;
        end else if (front_sel) begin
            rd_color <= fb1_mem[rd_addr];
        end else begin
            rd_color <= fb0_mem[rd_addr];
        end
    end

endmodule

/* src/raster_backend.sv */
`timescale 1ns/1ps

module raster_backend import raster_pkg::*; #(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input  logic              clk_render,
    input  logic              rst_render,
    input  logic              frame_start,
    input  color12_t          fill_color,
    input  fragment_t         frag_in,
    input  logic [scan_w-1:0] scan_x,
    input  logic [scan_w-1:0] scan_y,
    input  logic              scan_de,
    output logic              busy,
    output color16_t          video
);

    // ------------------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------------------
    fragment_t          frag_mid;
    logic               swap;
    fb_write_t          fb_wr;
    logic [coord_w-1:0] rd_x;
    logic [coord_w-1:0] rd_y;
    color16_t           rd_color;

    // Clear sweep and fragment merge
    clear_sweep #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_clear_sweep (
        .clk_render  (clk_render),
        .rst_render  (rst_render),
        .frame_start (frame_start),
        .fill_color  (fill_color),
        .frag_in     (frag_in),
        .frag_out    (frag_mid),
        .swap        (swap),
        .busy        (busy)
    );

    depth_test #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_depth_test (
        .clk_render (clk_render),
        .rst_render (rst_render),
        .frag       (frag_mid),
        .fb_wr      (fb_wr)
    );

    // Double-buffered colour store
    frame_store #(
        .WIDTH  (WIDTH),
        .HEIGHT (HEIGHT)
    ) u_frame_store (
        .clk_render (clk_render),
        .rst_render (rst_render),
        .swap       (swap),
        .fb_wr      (fb_wr),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .rd_color   (rd_color)
    );

    scan_out u_scan_out (
        .clk_render (clk_render),
        .rst_render (rst_render),
        .scan_x     (scan_x),
        .scan_y     (scan_y),
        .scan_de    (scan_de),
        .rd_color   (rd_color),
        .rd_x       (rd_x),
        .rd_y       (rd_y),
        .video      (video)
    );

endmodule

/* src/raster_pkg.sv */
package raster_pkg;

    // ------------------------------------------------------------------------
    // Widths and depth range
    // ------------------------------------------------------------------------
    localparam int coord_w = 16;
    localparam int scan_w  = 10;

    localparam int near_plane = 1;
    localparam int far_plane  = 1000;

    // 16 fractional bits on top of the far-to-near span
    localparam int depth_w = 16 + $clog2(far_plane - near_plane);

    localparam logic [depth_w-1:0] depth_max = '1;

    // ------------------------------------------------------------------------
    // Colour and fragment types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color12_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } color16_t;

    typedef struct packed {
        logic               valid;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        logic [depth_w-1:0] depth;
        color16_t           color;
        logic               compare_depth;
    } fragment_t;

    // Depth test result towards the frame store
    typedef struct packed {
        logic               en;
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        color16_t           color;
    } fb_write_t;

    typedef enum logic {
        SWEEP_IDLE,
        SWEEP_RUN
    } sweep_state_e;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_FORCE,
        OP_PASS,
        OP_REJECT
    } depth_op_e;

    // Widen 4-bit fields by replicating their top bits
    function automatic color16_t expand_color(input color12_t c);
        color16_t w;
        w.r = {c.r, c.r[3]};
        w.g = {c.g, c.g[3:2]};
        w.b = {c.b, c.b[3]};
        return w;
    endfunction

    // Row-major pixel index
    function automatic int unsigned pixel_index(input logic [coord_w-1:0] x,
                                                input logic [coord_w-1:0] y,
                                                input int unsigned width);
        return y * width + x;
    endfunction

endpackage

/* src/scan_out.sv */
`timescale 1ns/1ps

module scan_out import raster_pkg::*; (
    input  logic               clk_render,
    input  logic               rst_render,
    input  logic [scan_w-1:0]  scan_x,
    input  logic [scan_w-1:0]  scan_y,
    input  logic               scan_de,
    input  color16_t           rd_color,
    output logic [coord_w-1:0] rd_x,
    output logic [coord_w-1:0] rd_y,
    output color16_t           video
);

    logic [scan_w-1:0] sum_x;
    logic              de_d;

    // Half resolution, x rounded up by one to line up with the read latency
    assign sum_x = scan_x + scan_w'(1);
    assign rd_x  = coord_w'(sum_x[scan_w-1:1]);
    assign rd_y  = coord_w'(scan_y[scan_w-1:1]);

    // de delayed to match the frame store read
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            de_d <= 1'b0;
        end else begin
            de_d <= scan_de;
        end
    end

    // Blank outside active video
    always_ff @(posedge clk_render or posedge rst_render) begin
        if (rst_render) begin
            video <= '0;
        end else if (de_d) begin
            video <= rd_color;
        end else begin
            video <= '0;
        end
    end

endmodule

/* test/raster_backend_assert.sv */
`timescale 1ns/1ps

module raster_backend_assert import raster_pkg::*; #(
    parameter int WIDTH  = 320,
    parameter int HEIGHT = 240
) (
    input logic               clk_render,
    input logic               rst_render,
    input fb_write_t          fb_wr,
    input logic               s1_valid,
    input fragment_t          s1_frag,
    input logic [depth_w-1:0] stored_depth
);

    int fail_count = 0;

    no_write_in_reset: assert property (
        @(posedge clk_render) rst_render |-> (fb_wr.en !== 1'b1)
    ) else begin
        fail_count++;
        $error("frame store write enabled during reset");
    end

    // Writes stay inside the frame
    write_in_frame: assert property (
        @(posedge clk_render) disable iff (rst_render)
        fb_wr.en |-> (fb_wr.x < coord_w'(WIDTH)) && (fb_wr.y < coord_w'(HEIGHT))
    ) else begin
        fail_count++;
        $error("frame store write outside the frame at (%0d,%0d)", fb_wr.x, fb_wr.y);
    end

    // A compare-on fragment that is not strictly nearer than the depth memory
    // itself never reaches the frame store, whatever stage 1 forwarded
    no_write_on_reject: assert property (
        @(posedge clk_render) disable iff (rst_render)
        (s1_valid && s1_frag.compare_depth && (s1_frag.depth >= stored_depth))
            |=> !fb_wr.en
    ) else begin
        fail_count++;
        $error("frame store written after a rejected depth test");
    end

endmodule

bind depth_test raster_backend_assert #(
    .WIDTH  (WIDTH),
    .HEIGHT (HEIGHT)
) u_depth_assert (
    .clk_render   (clk_render),
    .rst_render   (rst_render),
    .fb_wr        (fb_wr),
    .s1_valid     (s1_valid),
    .s1_frag      (s1_frag),
    .stored_depth (depth_mem[s1_addr])
);

/* test/raster_backend_tb.sv */
`timescale 1ns/1ps

module raster_backend_tb import raster_pkg::*; ();

    localparam int width         = 8;
    localparam int height        = 6;
    localparam int pix_n         = width * height;
    localparam int clk_period    = 40;
    localparam int run_cycles    = 2000;
    localparam int margin_cycles = 200;

    logic              clk_render;
    logic              rst_render;
    logic              frame_start;
    color12_t          fill_color;
    fragment_t         frag_in;
    logic [scan_w-1:0] scan_x;
    logic [scan_w-1:0] scan_y;
    logic              scan_de;
    logic              busy;
    color16_t          video;

    // Reference model, row-major
    color16_t           ref_fb [2][pix_n];
    logic [depth_w-1:0] ref_depth [pix_n];
    int                 front_buf = 0;

    logic [31:0] lfsr = 32'h578e;
    int          errors = 0;
    int          checks = 0;

    tb_clock_gen #(
        .PERIOD       (clk_period),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk_render (clk_render),
        .rst_render (rst_render)
    );

    raster_backend #(
        .WIDTH  (width),
        .HEIGHT (height)
    ) u_raster_backend (
        .clk_render  (clk_render),
        .rst_render  (rst_render),
        .frame_start (frame_start),
        .fill_color  (fill_color),
        .frag_in     (frag_in),
        .scan_x      (scan_x),
        .scan_y      (scan_y),
        .scan_de     (scan_de),
        .busy        (busy),
        .video       (video)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Top bits of each field repeated into the new low bits
    function automatic color16_t widen_fill(input color12_t c);
        return {c.r, c.r[3], c.g, c.g[3:2], c.b, c.b[3]};
    endfunction

    task automatic start_frame(input color12_t fill, input logic junk);
        int          n;
        int          i;
        logic [31:0] r;
        frag_in = '0;
        repeat (3) @(negedge clk_render);
        frame_start = 1'b1;
        fill_color  = fill;
        front_buf   = 1 - front_buf;
        for (i = 0; i < pix_n; i++) begin
            ref_fb[1 - front_buf][i] = widen_fill(fill);
            ref_depth[i] = '1;
        end
        @(negedge clk_render);
        frame_start = 1'b0;
        n = 0;
        while (busy) begin
            // Stray fragments and a repeated frame start, all to be ignored
            r = next_bits(16);
            frag_in = junk ? {1'b1, coord_w'(n % width), coord_w'(n % height),
                              depth_w'(0), r[15:0], 1'b0} : '0;
            frame_start = junk && (n == pix_n / 2);
            n++;
            @(negedge clk_render);
        end
        frame_start = 1'b0;
        frag_in = '0;
        repeat (3) @(negedge clk_render);
        checks++;
        assert (n == pix_n) else begin
            errors++;
            $display("MISMATCH at %0t: busy high for %0d cycles, expected %0d",
                     $time, n, pix_n);
        end
    endtask

    task automatic drive_frag(input int x, input int y, input int d,
                              input color16_t c, input logic cmp, input int gap);
        int idx;
        frag_in.valid         = 1'b1;
        frag_in.x             = coord_w'(x);
        frag_in.y             = coord_w'(y);
        frag_in.depth         = depth_w'(d);
        frag_in.color         = c;
        frag_in.compare_depth = cmp;
        // Off-screen fragments leave the model untouched
        if (x < width && y < height) begin
            idx = y * width + x;
            // Strictly nearer wins, compare off always writes
            if (!cmp || depth_w'(d) < ref_depth[idx]) begin
                ref_depth[idx] = depth_w'(d);
                ref_fb[1 - front_buf][idx] = c;
            end
        end
        @(negedge clk_render);
        if (gap > 0) begin
            frag_in = '0;
            repeat (gap) @(negedge clk_render);
        end
    endtask

    task automatic check_display(input logic de);
        int       px;
        int       py;
        int       sx;
        int       sy;
        color16_t expected;
        for (py = 0; py < height; py++) begin
            for (px = 0; px < width; px++) begin
                // Odd scan x lands on the next pixel only when rounded up
                sx = (px == 0) ? 0 : 2 * px - 1;
                sy = 2 * py + 1;
                scan_x  = scan_w'(sx);
                scan_y  = scan_w'(sy);
                scan_de = de;
                // Half resolution, x rounded up
                expected = de ? ref_fb[front_buf][(sy / 2) * width + (sx + 1) / 2] : '0;
                repeat (2) @(negedge clk_render);
                checks++;
                assert (video === expected) else begin
                    errors++;
                    $display("MISMATCH at %0t: scan (%0d,%0d) video %h, expected %h",
                             $time, sx, sy, video, expected);
                end
            end
        end
        scan_de = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic clear_and_swap();
        start_frame(12'h3a5, 1'b0);
        start_frame(12'hc18, 1'b0);
        check_display(1'b1);
    endtask

    task automatic nearest_depth_wins();
        start_frame(12'h0f0, 1'b0);
        drive_frag(2, 1, 500, 16'h1111, 1'b1, 2);
        drive_frag(2, 1, 300, 16'h2222, 1'b1, 2);
        // Tie keeps the earlier colour
        drive_frag(2, 1, 300, 16'h3333, 1'b1, 2);
        drive_frag(5, 4, 100, 16'h4444, 1'b1, 3);
        drive_frag(5, 4, 200, 16'h5555, 1'b1, 3);
        drive_frag(0, 5, 9, 16'h6666, 1'b1, 2);
        start_frame(12'h0f0, 1'b0);
        check_display(1'b1);
    endtask

    task automatic forced_write();
        start_frame(12'h800, 1'b0);
        drive_frag(3, 3, 50, 16'habcd, 1'b1, 2);
        drive_frag(3, 3, 900000, 16'h0123, 1'b0, 2);
        // Just past the right edge, would alias onto the next row
        drive_frag(width, 3, 1, 16'hdead, 1'b0, 2);
        start_frame(12'h800, 1'b0);
        check_display(1'b1);
    endtask

    task automatic back_to_back_hazard();
        logic [31:0] r;
        int          i;
        int          x;
        start_frame(12'h00f, 1'b0);
        for (i = 0; i < 12; i++) begin
            x = (next_bits(1) == 32'd1) ? 3 : 4;
            r = next_bits(16);
            // Narrow depth range so ties and wins both happen
            drive_frag(x, 2, next_bits(4), r[15:0], next_bits(3) != 32'd0, 0);
        end
        start_frame(12'h00f, 1'b0);
        check_display(1'b1);
    endtask

    task automatic double_buffering();
        drive_frag(4, 2, 10, 16'hf81f, 1'b1, 0);
        drive_frag(7, 5, 10, 16'h07e0, 1'b0, 2);
        check_display(1'b1);
        start_frame(12'h123, 1'b1);
        check_display(1'b1);
        // Sweep-time fragments would show up in this frame
        start_frame(12'h456, 1'b0);
        check_display(1'b1);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        frame_start = 1'b0;
        fill_color  = '0;
        frag_in     = '0;
        scan_x      = '0;
        scan_y      = '0;
        scan_de     = 1'b0;
        wait (!rst_render);
        @(negedge clk_render);
        checks++;
        assert (busy === 1'b0 && video === 16'h0) else begin
            errors++;
            $display("MISMATCH at %0t: busy %b video %h after reset", $time, busy, video);
        end
        clear_and_swap();
        nearest_depth_wins();
        forced_write();
        back_to_back_hazard();
        double_buffering();
        check_display(1'b0);
        errors += u_raster_backend.u_depth_test.u_depth_assert.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #((run_cycles + margin_cycles) * clk_period);
        $display("Timeout: the run did not finish within %0d cycles",
                 run_cycles + margin_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_render,
    output logic rst_render
);

    initial begin
        clk_render = 1'b0;
        forever begin
            #(PERIOD / 2) clk_render = ~clk_render;
        end
    end

    // Reset spans the first rising edges, released on a falling edge
    initial begin
        rst_render = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_render);
        @(negedge clk_render);
        rst_render = 1'b0;
    end

endmodule
